// File: design/soc_pkg.sv
// shared definitions for the load/store bus
// widths, address map, size encoding, address views

`default_nettype none

package soc_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned XLEN = 32;
  localparam int unsigned BLEN = XLEN/8;
  localparam int unsigned BLOG = $clog2(BLEN);
  localparam int unsigned GW   = 32;

  // data memory, 16 KiB
  localparam int unsigned MEM_ADR = 14;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // 1 selects the peripheral region
  localparam int unsigned REGION_BIT = 14;
  // 1 selects the empty slot, 0 the GPIO controller
  localparam int unsigned SLOT_BIT = 6;

  // log2 transfer size, code 3 is invalid
  typedef enum logic [1:0] {
    SIZ_BYTE = 2'd0,
    SIZ_HALF = 2'd1,
    SIZ_WORD = 2'd2
  } siz_t;

  // GPIO register index, index 3 reads zero
  typedef enum logic [1:0] {
    GPIO_OUT = 2'd0,
    GPIO_ENA = 2'd1,
    GPIO_IN  = 2'd2
  } gpio_reg_t;

  // memory view of the address
  typedef struct packed {
    logic [XLEN-REGION_BIT-2:0] hig;
    logic                       rgn;
    logic [REGION_BIT-BLOG-1:0] wrd;
    logic [BLOG-1:0]            off;
  } mem_adr_t;

  // peripheral view of the address
  typedef struct packed {
    logic [XLEN-REGION_BIT-2:0]     hig;
    logic                           rgn;
    logic [REGION_BIT-SLOT_BIT-2:0] rsv_hi;
    logic                           slt;
    logic [SLOT_BIT-BLOG-3:0]       rsv_lo;
    gpio_reg_t                      idx;
    logic [BLOG-1:0]                off;
  } per_adr_t;

  typedef union packed {
    mem_adr_t mem;
    per_adr_t per;
  } adr_t;

endpackage: soc_pkg

`default_nettype wire

// File: design/tcb_if.sv
// internal bus interface
// request from manager, response from subordinate

`default_nettype none

interface tcb_if (
  input logic clk,
  input logic rst
);

  // request
  logic                       vld;
  logic                       wen;
  soc_pkg::adr_t              adr;
  logic [soc_pkg::BLEN-1:0]   ben;
  logic [soc_pkg::XLEN-1:0]   wdt;
  // response, no ready, target always accepts
  logic [soc_pkg::XLEN-1:0]   rdt;
  logic                       err;

  modport man (
    input  clk, rst,
    output vld, wen, adr, ben, wdt,
    input  rdt, err
  );

  modport sub (
    input  clk, rst,
    input  vld, wen, adr, ben, wdt,
    output rdt, err
  );

endinterface: tcb_if

`default_nettype wire

// File: design/tcb_size2ben.sv
// log2 size request to byte enable request
// misalign check, write data replication, read data realignment

`default_nettype none

module tcb_size2ben (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     vld,
  input  logic                     wen,
  input  soc_pkg::adr_t            adr,
  input  soc_pkg::siz_t            siz,
  input  logic [soc_pkg::XLEN-1:0] wdt,
  output logic [soc_pkg::XLEN-1:0] rdt,
  output logic                     err,
  tcb_if.man                       man
);

  logic [soc_pkg::BLOG-1:0] off;
  logic                     mis;
  logic [soc_pkg::BLEN-1:0] ben;
  logic [soc_pkg::XLEN-1:0] wdt_rep;
  // response side state
  logic [soc_pkg::BLOG-1:0] off_r;
  soc_pkg::siz_t            siz_r;
  logic                     mis_r;
  logic [soc_pkg::XLEN-1:0] sft;

  assign off = adr.mem.off;

  ////////////////////////////////////////
  // request
  ////////////////////////////////////////

  always_comb begin
    mis     = 1'b0;
    ben     = '0;
    wdt_rep = wdt;
    case (siz)
      soc_pkg::SIZ_BYTE: begin
        ben     = soc_pkg::BLEN'(1) << off;
        wdt_rep = {soc_pkg::BLEN{wdt[7:0]}};
      end
      soc_pkg::SIZ_HALF: begin
        mis     = off[0];
        ben     = soc_pkg::BLEN'(3) << off;
        wdt_rep = {(soc_pkg::BLEN/2){wdt[15:0]}};
      end
      soc_pkg::SIZ_WORD: begin
        mis     = |off;
        ben     = '1;
      end
      // code 3
      default: mis = 1'b1;
    endcase
  end

  // misaligned requests stay off the bus
  assign man.vld = vld & ~mis;
  assign man.wen = wen;
  assign man.adr = adr;
  assign man.ben = ben;
  assign man.wdt = wdt_rep;

  always_ff @(posedge clk) begin
    if (rst) begin
      mis_r <= 1'b0;
      off_r <= '0;
      siz_r <= soc_pkg::SIZ_WORD;
    end else if (vld) begin
      mis_r <= mis;
      off_r <= off;
      siz_r <= siz;
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // move the addressed lane down to bit 0
  assign sft = man.rdt >> {off_r, 3'b000};

  // misaligned request never reached a target
  always_comb begin
    if (mis_r) begin
      rdt = '0;
    end else begin
      case (siz_r)
        soc_pkg::SIZ_BYTE: rdt = {{(soc_pkg::XLEN-8){1'b0}}, sft[7:0]};
        soc_pkg::SIZ_HALF: rdt = {{(soc_pkg::XLEN-16){1'b0}}, sft[15:0]};
        default:           rdt = sft;
      endcase
    end
  end

  assign err = mis_r | man.err;

endmodule: tcb_size2ben

`default_nettype wire

// File: design/tcb_region_demux.sv
// region decoder and demultiplexer
// data memory, peripherals, error response for unmapped space

`default_nettype none

module tcb_region_demux (
  tcb_if.sub sub,
  tcb_if.man mem,
  tcb_if.man per
);

  logic unm;
  logic is_mem;
  logic is_per;
  // target of the request accepted on the last edge
  logic sel_mem_r;
  logic sel_per_r;
  logic sel_unm_r;

  // any high bit set is outside the map
  assign unm    = |sub.adr.mem.hig;
  assign is_per = ~unm &  sub.adr.mem.rgn;
  assign is_mem = ~unm & ~sub.adr.mem.rgn;

  // request fields go to both, vld only to the selected one
  assign mem.vld = sub.vld & is_mem;
  assign mem.wen = sub.wen;
  assign mem.adr = sub.adr;
  assign mem.ben = sub.ben;
  assign mem.wdt = sub.wdt;

  assign per.vld = sub.vld & is_per;
  assign per.wen = sub.wen;
  assign per.adr = sub.adr;
  assign per.ben = sub.ben;
  assign per.wdt = sub.wdt;

  always_ff @(posedge sub.clk) begin
    if (sub.rst) begin
      sel_mem_r <= 1'b0;
      sel_per_r <= 1'b0;
      sel_unm_r <= 1'b0;
    end else if (sub.vld) begin
      sel_mem_r <= is_mem;
      sel_per_r <= is_per;
      sel_unm_r <= unm;
    end
  end

  // response steering
  always_comb begin
    if (sel_mem_r) begin
      sub.rdt = mem.rdt;
      sub.err = mem.err;
    end else if (sel_per_r) begin
      sub.rdt = per.rdt;
      sub.err = per.err;
    end else begin
      sub.rdt = '0;
      sub.err = sel_unm_r;
    end
  end

endmodule: tcb_region_demux

`default_nettype wire

// File: design/soc_data_memory.sv
// data memory
// byte enable writes, one cycle read latency

`default_nettype none

module soc_data_memory (
  tcb_if.sub bus
);

  localparam int unsigned DEPTH = 2**(soc_pkg::MEM_ADR - soc_pkg::BLOG);

  logic [soc_pkg::XLEN-1:0] mem [0:DEPTH-1];
  logic [soc_pkg::MEM_ADR-soc_pkg::BLOG-1:0] idx;

  // word index from the memory view
  assign idx = bus.adr.mem.wrd;

  ////////////////////////////////////////
  // write
  ////////////////////////////////////////

  always_ff @(posedge bus.clk) begin
    if (bus.vld & bus.wen) begin
      for (int b = 0; b < soc_pkg::BLEN; b++) begin
        if (bus.ben[b]) begin
          mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read
  ////////////////////////////////////////

  // full word, lane select is done upstream
  always_ff @(posedge bus.clk) begin
    if (bus.vld & ~bus.wen) begin
      bus.rdt <= mem[idx];
    end
  end

  assign bus.err = 1'b0;

endmodule: soc_data_memory

`default_nettype wire

// File: design/tcb_peri_bridge.sv
// peripheral bridge
// request register from delay 1 to delay 0, slot decode

`default_nettype none

module tcb_peri_bridge (
  tcb_if.sub sub,
  tcb_if.man gpio
);

  logic                     vld_r;
  logic                     wen_r;
  soc_pkg::adr_t            adr_r;
  logic [soc_pkg::BLEN-1:0] ben_r;
  logic [soc_pkg::XLEN-1:0] wdt_r;
  logic                     slt;

  ////////////////////////////////////////
  // request register
  ////////////////////////////////////////

  always_ff @(posedge sub.clk) begin
    if (sub.rst) begin
      vld_r <= 1'b0;
    end else begin
      vld_r <= sub.vld;
    end
  end

  // payload is captured only on a valid request
  always_ff @(posedge sub.clk) begin
    if (sub.vld) begin
      wen_r <= sub.wen;
      adr_r <= sub.adr;
      ben_r <= sub.ben;
      wdt_r <= sub.wdt;
    end
  end

  ////////////////////////////////////////
  // slot decode
  ////////////////////////////////////////

  assign slt = adr_r.per.slt;

  // slot 0 is GPIO
  assign gpio.vld = vld_r & ~slt;
  assign gpio.wen = wen_r;
  assign gpio.adr = adr_r;
  assign gpio.ben = ben_r;
  assign gpio.wdt = wdt_r;

  // slot 1 is empty and answers with an error
  assign sub.rdt = slt ? '0 : gpio.rdt;
  assign sub.err = slt | gpio.err;

endmodule: tcb_peri_bridge

`default_nettype wire

// File: design/tcb_peri_gpio.sv
// GPIO controller
// output and enable registers, live input read

`default_nettype none

module tcb_peri_gpio (
  tcb_if.sub                     bus,
  output logic [soc_pkg::GW-1:0] gpio_o,
  output logic [soc_pkg::GW-1:0] gpio_e,
  input  logic [soc_pkg::GW-1:0] gpio_i
);

  soc_pkg::gpio_reg_t idx;
  logic               wen_o;
  logic               wen_e;

  assign idx = bus.adr.per.idx;

  // IN and index 3 ignore writes
  assign wen_o = bus.vld & bus.wen & (idx == soc_pkg::GPIO_OUT);
  assign wen_e = bus.vld & bus.wen & (idx == soc_pkg::GPIO_ENA);

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge bus.clk) begin
    if (bus.rst) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else begin
      for (int b = 0; b < soc_pkg::BLEN; b++) begin
        if (wen_o & bus.ben[b]) gpio_o[8*b +: 8] <= bus.wdt[8*b +: 8];
        if (wen_e & bus.ben[b]) gpio_e[8*b +: 8] <= bus.wdt[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // read, same cycle
  ////////////////////////////////////////

  always_comb begin
    case (idx)
      soc_pkg::GPIO_OUT: bus.rdt = gpio_o;
      soc_pkg::GPIO_ENA: bus.rdt = gpio_e;
      soc_pkg::GPIO_IN:  bus.rdt = gpio_i;
      default:           bus.rdt = '0;
    endcase
  end

  assign bus.err = 1'b0;

endmodule: tcb_peri_gpio

`default_nettype wire

// File: design/soc_bus_top.sv
// load/store bus top level
// size converter, region demux, data memory, peripheral bridge, GPIO

`default_nettype none

module soc_bus_top (
  input  logic                     clk,
  input  logic                     rst,
  // request
  input  logic                     vld,
  input  logic                     wen,
  input  soc_pkg::adr_t            adr,
  input  soc_pkg::siz_t            siz,
  input  logic [soc_pkg::XLEN-1:0] wdt,
  // response
  output logic [soc_pkg::XLEN-1:0] rdt,
  output logic                     err,
  // GPIO pins
  output logic [soc_pkg::GW-1:0]   gpio_o,
  output logic [soc_pkg::GW-1:0]   gpio_e,
  input  logic [soc_pkg::GW-1:0]   gpio_i
);

  ////////////////////////////////////////
  // busses
  ////////////////////////////////////////

  // byte enable bus, delay 1
  tcb_if tcb_lsu  (.clk (clk), .rst (rst));
  // data memory, delay 1
  tcb_if tcb_mem  (.clk (clk), .rst (rst));
  // peripheral region, delay 1
  tcb_if tcb_per  (.clk (clk), .rst (rst));
  // GPIO slot, delay 0
  tcb_if tcb_gpio (.clk (clk), .rst (rst));

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////

  tcb_size2ben size2ben (
    .clk (clk),
    .rst (rst),
    .vld (vld),
    .wen (wen),
    .adr (adr),
    .siz (siz),
    .wdt (wdt),
    .rdt (rdt),
    .err (err),
    .man (tcb_lsu)
  );

  tcb_region_demux demux (.sub (tcb_lsu), .mem (tcb_mem), .per (tcb_per));

  soc_data_memory dmem (.bus (tcb_mem));

  tcb_peri_bridge bridge (.sub (tcb_per), .gpio (tcb_gpio));

  tcb_peri_gpio gpio (
    .bus    (tcb_gpio),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

endmodule: soc_bus_top

`default_nettype wire

// File: test/soc_bus_props.sv
// concurrent checks on the top level ports
// error response shape, GPIO reset state, misalign error timing

`default_nettype none

module soc_bus_props (
  input logic                     clk,
  input logic                     rst,
  input logic                     vld,
  input soc_pkg::adr_t            adr,
  input soc_pkg::siz_t            siz,
  input logic [soc_pkg::XLEN-1:0] rdt,
  input logic                     err,
  input logic [soc_pkg::GW-1:0]   gpio_o,
  input logic [soc_pkg::GW-1:0]   gpio_e
);

  logic mis;

  // odd half, unaligned word, size code 3
  always_comb begin
    case (siz)
      soc_pkg::SIZ_BYTE: mis = 1'b0;
      soc_pkg::SIZ_HALF: mis = adr.mem.off[0];
      soc_pkg::SIZ_WORD: mis = |adr.mem.off;
      default:           mis = 1'b1;
    endcase
  end

  a_err_rdt_zero: assert property (@(posedge clk) disable iff (rst) err |-> (rdt == '0))
    else $error("rdt not zero on an error response");

  a_gpio_reset: assert property (@(posedge clk) $fell(rst) |-> (gpio_o == '0) && (gpio_e == '0))
    else $error("gpio outputs not cleared by reset");

  a_mis_err: assert property (@(posedge clk) disable iff (rst) (vld && mis) |=> err)
    else $error("no error response after a misaligned request");

endmodule: soc_bus_props

bind soc_bus_top soc_bus_props props (
  .clk    (clk),
  .rst    (rst),
  .vld    (vld),
  .adr    (adr),
  .siz    (siz),
  .rdt    (rdt),
  .err    (err),
  .gpio_o (gpio_o),
  .gpio_e (gpio_e)
);

`default_nettype wire

// File: test/soc_bus_tb.sv
// testbench for the load/store bus
// LFSR stimulus, reference model, response compare, timeout

`default_nettype none

module soc_bus_tb;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     vld;
  logic                     wen;
  soc_pkg::adr_t            adr;
  soc_pkg::siz_t            siz;
  logic [soc_pkg::XLEN-1:0] wdt;
  logic [soc_pkg::XLEN-1:0] rdt;
  logic                     err;
  logic [soc_pkg::GW-1:0]   gpio_o;
  logic [soc_pkg::GW-1:0]   gpio_e;
  logic [soc_pkg::GW-1:0]   gpio_i;

  // reference state
  logic [7:0]               mem_m [0:2**soc_pkg::MEM_ADR-1];
  logic [soc_pkg::GW-1:0]   out_m;
  logic [soc_pkg::GW-1:0]   ena_m;
  logic [31:0]              lfsr;
  // expected responses in issue order
  logic [soc_pkg::XLEN-1:0] exp_rdt_q [$];
  logic                     exp_err_q [$];
  logic                     exp_chk_q [$];
  // written addresses and sizes, for the read back
  logic [31:0]              wr_adr_q [$];
  logic [1:0]               wr_siz_q [$];
  logic                     acc;
  int                       n_req = 0;
  int                       n_chk = 0;
  int                       cycles = 0;

  soc_bus_top uut (
    .clk    (clk),
    .rst    (rst),
    .vld    (vld),
    .wen    (wen),
    .adr    (adr),
    .siz    (siz),
    .wdt    (wdt),
    .rdt    (rdt),
    .err    (err),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////

  // galois, right shift, x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // {err, rdt} for a request against the current model state
  function automatic logic [32:0] expected_resp(input logic w, input logic [31:0] a,
                                                input logic [1:0] s);
    logic [31:0] word;
    logic [31:0] val;
    logic        mis;
    word = '0;
    val = '0;
    case (s)
      2'd0:    mis = 1'b0;
      2'd1:    mis = a[0];
      2'd2:    mis = |a[1:0];
      default: mis = 1'b1;
    endcase
    // misaligned, outside the map, or the empty slot
    if (mis || (|a[31:soc_pkg::REGION_BIT+1]) ||
        (a[soc_pkg::REGION_BIT] && a[soc_pkg::SLOT_BIT])) begin
      return {1'b1, 32'h0};
    end
    if (a[soc_pkg::REGION_BIT]) begin
      case (a[3:2])
        2'd0:    word = out_m;
        2'd1:    word = ena_m;
        2'd2:    word = gpio_i;
        default: word = '0;
      endcase
    end else begin
      for (int k = 0; k < 4; k++) begin
        word[8*k +: 8] = mem_m[{a[13:2], 2'b00} + 14'(k)];
      end
    end
    if (w) begin
      return {1'b0, 32'h0};
    end
    // bytes from the offset upward, zero above the size
    for (int k = 0; k < (1 << s); k++) begin
      val[8*k +: 8] = word[8*(int'(a[1:0]) + k) +: 8];
    end
    return {1'b0, val};
  endfunction

  task automatic apply_write(input logic [31:0] a, input logic [1:0] s,
                             input logic [soc_pkg::XLEN-1:0] d);
    logic [32:0] r;
    int          n;
    int          off;
    r = expected_resp(1'b1, a, s);
    n = 1 << s;
    off = int'(a[1:0]);
    // rejected writes change nothing
    if (!r[32]) begin
      for (int k = 0; k < n; k++) begin
        if (!a[soc_pkg::REGION_BIT]) begin
          mem_m[{a[13:2], 2'b00} + 14'(off + k)] = d[8*k +: 8];
        end else if (a[3:2] == 2'd0) begin
          out_m[8*(off+k) +: 8] = d[8*k +: 8];
        end else if (a[3:2] == 2'd1) begin
          ena_m[8*(off+k) +: 8] = d[8*k +: 8];
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_rdt(input logic [soc_pkg::XLEN-1:0] want,
                           input logic [soc_pkg::XLEN-1:0] got);
    if (got !== want) begin
      $display("ERROR %0t rdt expected %h actual %h", $time, want, got);
      $display("sim failed");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_err(input logic want, input logic got);
    if (got !== want) begin
      $display("ERROR %0t err expected %b actual %b", $time, want, got);
      $display("sim failed");
      $fatal(1, "error flag mismatch");
    end
  endtask

  task automatic check_gpio(input string name, input logic [soc_pkg::GW-1:0] want,
                            input logic [soc_pkg::GW-1:0] got);
    if (got !== want) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, want, got);
      $display("sim failed");
      $fatal(1, "gpio port mismatch");
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic send_req(input logic w, input logic [31:0] a, input logic [1:0] s,
                          input logic [soc_pkg::XLEN-1:0] d);
    logic [32:0] r;
    r = expected_resp(w, a, s);
    exp_rdt_q.push_back(r[31:0]);
    exp_err_q.push_back(r[32]);
    // rdt of an accepted write carries nothing
    exp_chk_q.push_back(~w | r[32]);
    if (w) begin
      apply_write(a, s, d);
    end
    n_req++;
    vld = 1'b1;
    wen = w;
    adr = a;
    siz = soc_pkg::siz_t'(s);
    wdt = d;
    @(posedge clk);
    #1;
    vld = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    vld = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic pick_aligned(output logic [1:0] s, output logic [1:0] off);
    logic [31:0] t;
    t = lfsr_bits(4);
    s = (t[1:0] == 2'd3) ? 2'd2 : t[1:0];
    case (s)
      2'd0:    off = t[3:2];
      2'd1:    off = {t[3], 1'b0};
      default: off = 2'd0;
    endcase
  endtask

  // odd half, unaligned word, or size code 3
  task automatic pick_misaligned(output logic [1:0] s, output logic [1:0] off);
    logic [31:0] t;
    t = lfsr_bits(4);
    case (t[1:0])
      2'd1: begin
        s = 2'd2;
        off = (t[3:2] == 2'd0) ? 2'd1 : t[3:2];
      end
      2'd2: begin
        s = 2'd3;
        off = t[3:2];
      end
      default: begin
        s = 2'd1;
        off = {t[3], 1'b1};
      end
    endcase
  endtask

  ////////////////////////////////////////
  // response compare and timeout
  ////////////////////////////////////////

  always @(posedge clk) begin
    acc <= vld & ~rst;
  end

  // response of the last edge, stable around the falling edge
  always @(negedge clk) begin
    logic [soc_pkg::XLEN-1:0] e_rdt;
    logic                     e_err;
    logic                     e_chk;
    if (acc) begin
      e_rdt = exp_rdt_q.pop_front();
      e_err = exp_err_q.pop_front();
      e_chk = exp_chk_q.pop_front();
      check_err(e_err, err);
      if (e_chk) begin
        check_rdt(e_rdt, rdt);
      end
      n_chk++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    // traffic takes about 1700 cycles
    if (cycles >= 3000) begin
      $display("timeout, run did not end within 3000 cycles");
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] t;
    logic [31:0] u;
    logic [1:0]  s;
    logic [1:0]  off;
    rst = 1'b1;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    siz = soc_pkg::SIZ_WORD;
    wdt = '0;
    gpio_i = '0;
    out_m = '0;
    ena_m = '0;
    lfsr = 32'h197dc0c5;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    check_gpio("gpio_o", '0, gpio_o);
    check_gpio("gpio_e", '0, gpio_e);

    // fill words 0 to 63 so every later read is known
    for (int i = 0; i < 64; i++) begin
      send_req(1'b1, {24'h0, 6'(i), 2'b00}, 2'd2, lfsr_bits(32));
    end
    // back to back aligned writes, then read them back
    for (int i = 0; i < 256; i++) begin
      pick_aligned(s, off);
      t = lfsr_bits(6);
      a = {24'h0, t[5:0], off};
      wr_adr_q.push_back(a);
      wr_siz_q.push_back(s);
      send_req(1'b1, a, s, lfsr_bits(32));
    end
    foreach (wr_adr_q[i]) begin
      send_req(1'b0, wr_adr_q[i], wr_siz_q[i], '0);
    end

    // misaligned, then the whole word still holds the old value
    for (int i = 0; i < 16; i++) begin
      pick_misaligned(s, off);
      t = lfsr_bits(7);
      a = {24'h0, t[5:0], off};
      send_req(t[6], a, s, lfsr_bits(32));
      send_req(1'b0, {a[31:2], 2'b00}, 2'd2, '0);
    end
    send_req(1'b1, 32'h0000_4001, 2'd1, 32'hffff_ffff);
    send_req(1'b1, 32'h0000_4006, 2'd2, 32'hffff_ffff);

    // unmapped space and the empty slot
    for (int i = 0; i < 8; i++) begin
      t = lfsr_bits(17);
      if (t[16:0] == '0) begin
        t = 32'h1;
      end
      u = lfsr_bits(15);
      a = {t[16:0], u[14:2], 2'b00};
      send_req(1'b1, a, 2'd2, lfsr_bits(32));
      send_req(1'b0, a, 2'd2, '0);
      a = {28'h000_0404, u[1:0], 2'b00};
      send_req(1'b1, a, 2'd2, lfsr_bits(32));
      send_req(1'b0, a, 2'd2, '0);
    end

    // GPIO partial writes, visible at the pins two edges later
    gpio_i = lfsr_bits(32);
    for (int i = 0; i < 12; i++) begin
      pick_aligned(s, off);
      t = lfsr_bits(1);
      send_req(1'b1, {28'h000_0400, 1'b0, t[0], off}, s, lfsr_bits(32));
      idle_cycles(2);
      check_gpio("gpio_o", out_m, gpio_o);
      check_gpio("gpio_e", ena_m, gpio_e);
    end
    // IN and index 3 drop writes
    send_req(1'b1, 32'h0000_4008, 2'd2, lfsr_bits(32));
    send_req(1'b1, 32'h0000_400c, 2'd2, lfsr_bits(32));
    for (int i = 0; i < 16; i++) begin
      pick_aligned(s, off);
      t = lfsr_bits(2);
      send_req(1'b0, {28'h000_0400, t[1:0], off}, s, '0);
    end

    // mixed traffic, one request per cycle
    for (int i = 0; i < 1000; i++) begin
      t = lfsr_bits(4);
      u = lfsr_bits(6);
      pick_aligned(s, off);
      case (t[2:0])
        3'd4, 3'd5: a = {28'h000_0400, u[1:0], off};
        3'd6:       a = {28'h000_0404, u[1:0], off};
        3'd7: begin
          pick_misaligned(s, off);
          a = {24'h0, u[5:0], off};
        end
        default:    a = {24'h0, u[5:0], off};
      endcase
      send_req(t[3], a, s, lfsr_bits(32));
    end

    idle_cycles(2);
    check_gpio("gpio_o", out_m, gpio_o);
    check_gpio("gpio_e", ena_m, gpio_e);
    if (n_chk != n_req) begin
      $display("%0d requests sent but %0d responses checked", n_req, n_chk);
      $display("sim failed");
      $fatal(1, "missing responses");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule: soc_bus_tb

`default_nettype wire

// File: list.f
design/soc_pkg.sv
design/tcb_if.sv
design/tcb_size2ben.sv
design/tcb_region_demux.sv
design/soc_data_memory.sv
design/tcb_peri_bridge.sv
design/tcb_peri_gpio.sv
design/soc_bus_top.sv
test/soc_bus_props.sv
test/soc_bus_tb.sv

// File: run.sh
#!/bin/sh
# build and run the bus testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module soc_bus_tb -f list.f -o soc_bus_sim
./obj_dir/soc_bus_sim
